//--- priv_pkg.sv
package priv_pkg;

   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;

   typedef enum logic [1:0] {
      PRIV_U = 2'b00,
      PRIV_M = 2'b11
   } priv_mode_t;

   typedef enum logic [3:0] {
      OP_NONE,
      OP_CSRRW,
      OP_CSRRS,
      OP_CSRRC,
      OP_CSRRWI,
      OP_CSRRSI,
      OP_CSRRCI,
      OP_ECALL,
      OP_EBREAK,
      OP_MRET,
      OP_WFI
   } sys_op_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_COMMIT
   } ctrl_state_t;

   ////////////////////////////////////////
   // machine csr map
   ////////////////////////////////////////
   typedef enum logic [CSR_ADDR_W-1:0] {
      CSR_MSTATUS   = 12'h300,
      CSR_MISA      = 12'h301,
      CSR_MIE       = 12'h304,
      CSR_MTVEC     = 12'h305,
      CSR_MSCRATCH  = 12'h340,
      CSR_MEPC      = 12'h341,
      CSR_MCAUSE    = 12'h342,
      CSR_MTVAL     = 12'h343,
      CSR_MIP       = 12'h344,
      CSR_MINSTRET  = 12'hb02,
      CSR_MINSTRETH = 12'hb82,
      CSR_MHARTID   = 12'hf14
   } csr_addr_t;

   // mie, mpie and mpp
   localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;
   // msie, mtie and meie
   localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
   // mxl = 1, extensions I and U
   localparam logic [XLEN-1:0] MISA_VALUE    = 32'h4010_0100;

   ////////////////////////////////////////
   // trap causes
   ////////////////////////////////////////
   localparam logic [4:0] CAUSE_ILLEGAL = 5'd2;
   localparam logic [4:0] CAUSE_BREAK   = 5'd3;
   localparam logic [4:0] CAUSE_ECALL_U = 5'd8;
   localparam logic [4:0] CAUSE_ECALL_M = 5'd11;

   localparam logic [4:0] IRQ_SOFT  = 5'd3;
   localparam logic [4:0] IRQ_TIMER = 5'd7;
   localparam logic [4:0] IRQ_EXT   = 5'd11;

endpackage

//--- priv_decoder.sv
`timescale 1ns/100ps

module priv_decoder (
   input  logic [priv_pkg::XLEN-1:0]       instr,
   output priv_pkg::sys_op_t               op,
   output logic [priv_pkg::CSR_ADDR_W-1:0] csr_addr,
   output logic [4:0]                      rd_idx,
   output logic [4:0]                      rs1_field
);

   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   // funct3 = 0 system instructions are matched on the whole word
   localparam logic [priv_pkg::XLEN-1:0] INSTR_ECALL  = 32'h0000_0073;
   localparam logic [priv_pkg::XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;
   localparam logic [priv_pkg::XLEN-1:0] INSTR_MRET   = 32'h3020_0073;
   localparam logic [priv_pkg::XLEN-1:0] INSTR_WFI    = 32'h1050_0073;

   logic [6:0] opcode;
   logic [2:0] funct3;

   assign opcode    = instr[6:0];
   assign funct3    = instr[14:12];
   assign csr_addr  = instr[31:20];
   assign rd_idx    = instr[11:7];
   assign rs1_field = instr[19:15];

   always_comb begin
      op = priv_pkg::OP_NONE;
      if (opcode == OPC_SYSTEM) begin
         case (funct3)
            3'b001: op = priv_pkg::OP_CSRRW;
            3'b010: op = priv_pkg::OP_CSRRS;
            3'b011: op = priv_pkg::OP_CSRRC;
            3'b101: op = priv_pkg::OP_CSRRWI;
            3'b110: op = priv_pkg::OP_CSRRSI;
            3'b111: op = priv_pkg::OP_CSRRCI;
            3'b000: begin
               case (instr)
                  INSTR_ECALL:  op = priv_pkg::OP_ECALL;
                  INSTR_EBREAK: op = priv_pkg::OP_EBREAK;
                  INSTR_MRET:   op = priv_pkg::OP_MRET;
                  INSTR_WFI:    op = priv_pkg::OP_WFI;
                  default:      op = priv_pkg::OP_NONE;
               endcase
            end
            // funct3 = 4 is reserved
            default: op = priv_pkg::OP_NONE;
         endcase
      end
   end

endmodule

//--- csr_file.sv
`timescale 1ns/100ps

module csr_file (
   input  logic                            clk,
   input  logic                            rstn,
   input  priv_pkg::sys_op_t               op,
   input  logic [priv_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic [priv_pkg::XLEN-1:0]       operand,
   input  priv_pkg::priv_mode_t            mode,
   input  logic                            commit,
   input  logic                            retire,
   input  logic                            trap_enter,
   input  logic [priv_pkg::XLEN-1:0]       trap_cause,
   input  logic [priv_pkg::XLEN-1:0]       trap_epc,
   input  logic [priv_pkg::XLEN-1:0]       trap_tval,
   input  logic                            mret,
   input  logic                            ext_irq,
   input  logic                            sw_irq,
   input  logic                            timer_irq,
   output logic [priv_pkg::XLEN-1:0]       rdata,
   output logic                            csr_fault,
   output logic                            mstatus_mie,
   output priv_pkg::priv_mode_t            mstatus_mpp,
   output logic [priv_pkg::XLEN-1:0]       mie,
   output logic [priv_pkg::XLEN-1:0]       mtvec,
   output logic [priv_pkg::XLEN-1:0]       mepc
);

   logic [priv_pkg::XLEN-1:0] mstatus;
   logic [priv_pkg::XLEN-1:0] mscratch;
   logic [priv_pkg::XLEN-1:0] mcause;
   logic [priv_pkg::XLEN-1:0] mtval;
   logic [63:0]               minstret;
   logic [priv_pkg::XLEN-1:0] mip;

   logic                      is_csr_op;
   logic                      is_write;
   logic                      addr_known;
   logic                      wr_en;
   logic [priv_pkg::XLEN-1:0] wdata;
   logic [1:0]                mpp_wr;
   logic [priv_pkg::XLEN-1:0] mstatus_wr;

   // live view of the irq lines
   assign mip = {{(priv_pkg::XLEN-12){1'b0}}, ext_irq, 3'b0, timer_irq, 3'b0, sw_irq, 3'b0};

   // operand arrives as zero when the rs1 field is zero
   always_comb begin
      is_csr_op = 1'b1;
      is_write  = 1'b1;
      wdata     = operand;
      case (op)
         priv_pkg::OP_CSRRW, priv_pkg::OP_CSRRWI: wdata = operand;
         priv_pkg::OP_CSRRS, priv_pkg::OP_CSRRSI: begin
            wdata    = rdata | operand;
            is_write = (operand != '0);
         end
         priv_pkg::OP_CSRRC, priv_pkg::OP_CSRRCI: begin
            wdata    = rdata & ~operand;
            is_write = (operand != '0);
         end
         default: begin
            is_csr_op = 1'b0;
            is_write  = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////
   always_comb begin
      addr_known = 1'b1;
      case (csr_addr)
         priv_pkg::CSR_MSTATUS:   rdata = mstatus;
         priv_pkg::CSR_MISA:      rdata = priv_pkg::MISA_VALUE;
         priv_pkg::CSR_MIE:       rdata = mie;
         priv_pkg::CSR_MTVEC:     rdata = mtvec;
         priv_pkg::CSR_MSCRATCH:  rdata = mscratch;
         priv_pkg::CSR_MEPC:      rdata = mepc;
         priv_pkg::CSR_MCAUSE:    rdata = mcause;
         priv_pkg::CSR_MTVAL:     rdata = mtval;
         priv_pkg::CSR_MIP:       rdata = mip;
         priv_pkg::CSR_MINSTRET:  rdata = minstret[31:0];
         priv_pkg::CSR_MINSTRETH: rdata = minstret[63:32];
         priv_pkg::CSR_MHARTID:   rdata = '0;
         default: begin
            rdata      = '0;
            addr_known = 1'b0;
         end
      endcase
   end

   // top two address bits set means read only
   assign csr_fault = is_csr_op &&
                      (!addr_known || mode == priv_pkg::PRIV_U ||
                       (is_write && csr_addr[11:10] == 2'b11));

   assign wr_en = commit && is_write;

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////
   // mpp only holds U or M
   assign mpp_wr     = (wdata[12:11] == 2'b11) ? 2'b11 : 2'b00;
   assign mstatus_wr = (wr_en && csr_addr == priv_pkg::CSR_MSTATUS) ?
                       ({wdata[31:13], mpp_wr, wdata[10:0]} & priv_pkg::MSTATUS_WMASK) :
                       mstatus;

   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus  <= '0;
         mie      <= '0;
         mtvec    <= '0;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
         minstret <= '0;
      end else begin
         if (retire) begin
            minstret <= minstret + 64'd1;
         end
         // an explicit write beats the retire count
         if (wr_en) begin
            case (csr_addr)
               priv_pkg::CSR_MIE:       mie             <= wdata & priv_pkg::MIE_WMASK;
               priv_pkg::CSR_MSCRATCH:  mscratch        <= wdata;
               priv_pkg::CSR_MEPC:      mepc            <= {wdata[31:2], 2'b00};
               priv_pkg::CSR_MCAUSE:    mcause          <= wdata;
               priv_pkg::CSR_MTVAL:     mtval           <= wdata;
               priv_pkg::CSR_MINSTRET:  minstret[31:0]  <= wdata;
               priv_pkg::CSR_MINSTRETH: minstret[63:32] <= wdata;
               priv_pkg::CSR_MTVEC: begin
                  // modes 2 and 3 are reserved
                  if (!wdata[1]) begin
                     mtvec <= wdata;
                  end
               end
               default: ;
            endcase
         end
         if (trap_enter) begin
            mepc    <= {trap_epc[31:2], 2'b00};
            mcause  <= trap_cause;
            mtval   <= trap_tval;
            // mpp = mode, mpie = mie, mie = 0
            mstatus <= {mstatus_wr[31:13], mode, mstatus_wr[10:8], mstatus_wr[3],
                        mstatus_wr[6:4], 1'b0, mstatus_wr[2:0]};
         end else if (mret) begin
            // mpp = U, mpie = 1, mie = mpie
            mstatus <= {mstatus_wr[31:13], priv_pkg::PRIV_U, mstatus_wr[10:8], 1'b1,
                        mstatus_wr[6:4], mstatus_wr[7], mstatus_wr[2:0]};
         end else begin
            mstatus <= mstatus_wr;
         end
      end
   end

   assign mstatus_mie = mstatus[3];
   assign mstatus_mpp = priv_pkg::priv_mode_t'(mstatus[12:11]);

   // trap entry and return are exclusive per commit
   assert property (@(posedge clk) disable iff (rstn) !(trap_enter && mret));

   // the controller only writes accesses that passed the checks
   assert property (@(posedge clk) disable iff (rstn) commit |-> !csr_fault);

endmodule

//--- intr_ctrl.sv
`timescale 1ns/100ps

module intr_ctrl (
   input  logic                      ext_irq,
   input  logic                      sw_irq,
   input  logic                      timer_irq,
   input  logic [priv_pkg::XLEN-1:0] mie,
   input  logic                      mstatus_mie,
   input  priv_pkg::priv_mode_t      mode,
   output logic                      irq_pending,
   output logic [4:0]                irq_cause
);

   logic global_en;
   logic ext_take;
   logic sw_take;
   logic timer_take;

   // U mode always takes machine interrupts
   assign global_en = (mode == priv_pkg::PRIV_U) || mstatus_mie;

   assign ext_take   = ext_irq   && mie[priv_pkg::IRQ_EXT]   && global_en;
   assign sw_take    = sw_irq    && mie[priv_pkg::IRQ_SOFT]  && global_en;
   assign timer_take = timer_irq && mie[priv_pkg::IRQ_TIMER] && global_en;

   assign irq_pending = ext_take || sw_take || timer_take;

   // external first, then software, then timer
   always_comb begin
      if (ext_take) begin
         irq_cause = priv_pkg::IRQ_EXT;
      end else if (sw_take) begin
         irq_cause = priv_pkg::IRQ_SOFT;
      end else begin
         irq_cause = priv_pkg::IRQ_TIMER;
      end
   end

endmodule

//--- trap_ctrl.sv
`timescale 1ns/100ps

module trap_ctrl #(
   parameter logic [priv_pkg::XLEN-1:0] RESET_VECTOR = 32'h0000_1000
) (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            in_valid,
   input  logic [priv_pkg::XLEN-1:0]       in_pc,
   input  logic [priv_pkg::XLEN-1:0]       in_instr,
   input  logic [priv_pkg::XLEN-1:0]       in_rs1_value,
   input  priv_pkg::sys_op_t               op,
   input  logic [priv_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic [4:0]                      rd_idx,
   input  logic [4:0]                      rs1_field,
   input  logic [priv_pkg::XLEN-1:0]       rdata,
   input  logic                            csr_fault,
   input  priv_pkg::priv_mode_t            mstatus_mpp,
   input  logic [priv_pkg::XLEN-1:0]       mtvec,
   input  logic [priv_pkg::XLEN-1:0]       mepc,
   input  logic                            irq_pending,
   input  logic [4:0]                      irq_cause,
   output logic                            in_ready,
   output logic [priv_pkg::XLEN-1:0]       instr_q,
   output logic [priv_pkg::XLEN-1:0]       operand,
   output priv_pkg::priv_mode_t            mode,
   output logic                            commit,
   output logic                            retire,
   output logic                            trap_enter,
   output logic [priv_pkg::XLEN-1:0]       trap_cause,
   output logic [priv_pkg::XLEN-1:0]       trap_epc,
   output logic [priv_pkg::XLEN-1:0]       trap_tval,
   output logic                            mret,
   output logic                            res_valid,
   output logic [priv_pkg::XLEN-1:0]       res_rd_data,
   output logic                            res_rd_write,
   output logic [priv_pkg::XLEN-1:0]       res_next_pc,
   output logic                            res_trap
);

   localparam logic [priv_pkg::XLEN-1:0] INSTR_BYTES = 4;

   priv_pkg::ctrl_state_t     state;
   logic [priv_pkg::XLEN-1:0] pc_q;
   logic [priv_pkg::XLEN-1:0] rs1_q;
   logic [priv_pkg::XLEN-1:0] rdata_q;
   logic                      fault_q;

   logic                      is_csr_op;
   logic                      is_imm_op;
   logic                      exc_valid;
   logic [4:0]                exc_cause;
   logic                      irq_hold;
   logic                      take_irq;
   logic                      at_commit;
   logic                      rd_write;
   logic [priv_pkg::XLEN-1:0] tvec_base;
   logic [priv_pkg::XLEN-1:0] next_pc;

   ////////////////////////////////////////
   // exception check
   ////////////////////////////////////////
   always_comb begin
      is_csr_op = 1'b0;
      is_imm_op = 1'b0;
      exc_valid = 1'b0;
      exc_cause = priv_pkg::CAUSE_ILLEGAL;
      case (op)
         priv_pkg::OP_CSRRW, priv_pkg::OP_CSRRS, priv_pkg::OP_CSRRC: begin
            is_csr_op = 1'b1;
            exc_valid = fault_q;
         end
         priv_pkg::OP_CSRRWI, priv_pkg::OP_CSRRSI, priv_pkg::OP_CSRRCI: begin
            is_csr_op = 1'b1;
            is_imm_op = 1'b1;
            exc_valid = fault_q;
         end
         priv_pkg::OP_ECALL: begin
            exc_valid = 1'b1;
            exc_cause = (mode == priv_pkg::PRIV_U) ? priv_pkg::CAUSE_ECALL_U :
                                                     priv_pkg::CAUSE_ECALL_M;
         end
         priv_pkg::OP_EBREAK: begin
            exc_valid = 1'b1;
            exc_cause = priv_pkg::CAUSE_BREAK;
         end
         priv_pkg::OP_MRET: exc_valid = (mode == priv_pkg::PRIV_U);
         default: ;
      endcase
   end

   // x0 and a zero immediate both give a zero operand
   assign operand = (rs1_field == 5'd0) ? '0 :
                    is_imm_op ? {{(priv_pkg::XLEN-5){1'b0}}, rs1_field} : rs1_q;

   // trap setup changes settle before the next interrupt check
   assign irq_hold = (op == priv_pkg::OP_MRET) ||
                     (is_csr_op && (csr_addr == priv_pkg::CSR_MSTATUS ||
                                    csr_addr == priv_pkg::CSR_MIE ||
                                    csr_addr == priv_pkg::CSR_MTVEC));
   assign take_irq = irq_pending && !exc_valid && !irq_hold;

   assign at_commit  = (state == priv_pkg::ST_COMMIT);
   assign commit     = at_commit && is_csr_op && !fault_q;
   assign retire     = at_commit && !exc_valid;
   assign trap_enter = at_commit && (exc_valid || take_irq);
   assign mret       = at_commit && op == priv_pkg::OP_MRET && !exc_valid;
   assign rd_write   = is_csr_op && !exc_valid && rd_idx != 5'd0;

   // interrupts set bit 31 of mcause
   assign trap_cause = exc_valid ? {{(priv_pkg::XLEN-5){1'b0}}, exc_cause} :
                                   {1'b1, {(priv_pkg::XLEN-6){1'b0}}, irq_cause};
   assign trap_epc   = exc_valid ? pc_q : pc_q + INSTR_BYTES;
   assign trap_tval  = (exc_valid && exc_cause == priv_pkg::CAUSE_ILLEGAL) ? instr_q : '0;

   ////////////////////////////////////////
   // next pc
   ////////////////////////////////////////
   assign tvec_base = {mtvec[priv_pkg::XLEN-1:2], 2'b00};

   always_comb begin
      if (exc_valid) begin
         next_pc = tvec_base;
      end else if (take_irq && mtvec[0]) begin
         next_pc = tvec_base + {{(priv_pkg::XLEN-7){1'b0}}, irq_cause, 2'b00};
      end else if (take_irq) begin
         next_pc = tvec_base;
      end else if (op == priv_pkg::OP_MRET) begin
         next_pc = mepc;
      end else begin
         next_pc = pc_q + INSTR_BYTES;
      end
   end

   assign in_ready = (state == priv_pkg::ST_IDLE);

   always_ff @(posedge clk) begin
      if (rstn) begin
         state        <= priv_pkg::ST_IDLE;
         mode         <= priv_pkg::PRIV_M;
         res_valid    <= 1'b0;
         res_trap     <= 1'b0;
         res_rd_write <= 1'b0;
         res_next_pc  <= RESET_VECTOR;
      end else begin
         res_valid <= at_commit;
         case (state)
            priv_pkg::ST_IDLE: begin
               if (in_valid) begin
                  state <= priv_pkg::ST_EXEC;
               end
            end
            priv_pkg::ST_EXEC: state <= priv_pkg::ST_COMMIT;
            priv_pkg::ST_COMMIT: begin
               state        <= priv_pkg::ST_IDLE;
               res_trap     <= trap_enter;
               res_rd_write <= rd_write;
               res_next_pc  <= next_pc;
               if (trap_enter) begin
                  mode <= priv_pkg::PRIV_M;
               end else if (mret) begin
                  mode <= mstatus_mpp;
               end
            end
            default: state <= priv_pkg::ST_IDLE;
         endcase
      end
   end

   // instruction and read data
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         pc_q    <= in_pc;
         instr_q <= in_instr;
         rs1_q   <= in_rs1_value;
      end
      if (state == priv_pkg::ST_EXEC) begin
         rdata_q <= rdata;
         fault_q <= csr_fault;
      end
      if (at_commit) begin
         res_rd_data <= rd_write ? rdata_q : '0;
      end
   end

   // three cycles from acceptance to the next acceptance
   assert property (@(posedge clk) disable iff (rstn)
      in_valid && in_ready |=> !in_ready ##1 !in_ready ##1 in_ready);

   // no back-pressure on results, so a single-cycle pulse
   assert property (@(posedge clk) disable iff (rstn) res_valid |=> !res_valid);

endmodule

//--- priv_unit.sv
`timescale 1ns/100ps

module priv_unit #(
   parameter logic [priv_pkg::XLEN-1:0] RESET_VECTOR = 32'h0000_1000
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      in_valid,
   input  logic [priv_pkg::XLEN-1:0] in_pc,
   input  logic [priv_pkg::XLEN-1:0] in_instr,
   input  logic [priv_pkg::XLEN-1:0] in_rs1_value,
   input  logic                      ext_irq,
   input  logic                      sw_irq,
   input  logic                      timer_irq,
   output logic                      in_ready,
   output logic                      res_valid,
   output logic [priv_pkg::XLEN-1:0] res_rd_data,
   output logic                      res_rd_write,
   output logic [priv_pkg::XLEN-1:0] res_next_pc,
   output logic                      res_trap,
   output priv_pkg::priv_mode_t      priv_mode
);

   logic [priv_pkg::XLEN-1:0]       instr_q;
   priv_pkg::sys_op_t               op;
   logic [priv_pkg::CSR_ADDR_W-1:0] csr_addr;
   logic [4:0]                      rd_idx;
   logic [4:0]                      rs1_field;
   logic [priv_pkg::XLEN-1:0]       operand;
   logic                            commit;
   logic                            retire;
   logic                            trap_enter;
   logic [priv_pkg::XLEN-1:0]       trap_cause;
   logic [priv_pkg::XLEN-1:0]       trap_epc;
   logic [priv_pkg::XLEN-1:0]       trap_tval;
   logic                            mret;
   logic [priv_pkg::XLEN-1:0]       rdata;
   logic                            csr_fault;
   logic                            mstatus_mie;
   priv_pkg::priv_mode_t            mstatus_mpp;
   logic [priv_pkg::XLEN-1:0]       mie;
   logic [priv_pkg::XLEN-1:0]       mtvec;
   logic [priv_pkg::XLEN-1:0]       mepc;
   logic                            irq_pending;
   logic [4:0]                      irq_cause;

   // remaining ports connect by matching names
   priv_decoder u_decoder (.instr(instr_q), .*);

   csr_file u_csr_file (.mode(priv_mode), .*);

   intr_ctrl u_intr_ctrl (.mode(priv_mode), .*);

   trap_ctrl #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_trap_ctrl (
      .mode (priv_mode),
      .*
   );

endmodule

//--- tb_priv_unit.sv
`timescale 1ns/100ps

module tb_priv_unit;

   localparam logic [priv_pkg::XLEN-1:0] RESET_VECTOR = 32'h0000_1000;

   localparam int MAX_VECTORS      = 64;
   // pc, instr, rs1, ext, sw, timer, rd_write, rd_data, next_pc, trap, mode
   localparam int WORDS_PER_VECTOR = 11;
   // first word of the file is the vector count
   localparam int MEM_WORDS        = 1 + MAX_VECTORS * WORDS_PER_VECTOR;

   logic                      clk;
   logic                      rstn;
   logic                      in_valid;
   logic [priv_pkg::XLEN-1:0] in_pc;
   logic [priv_pkg::XLEN-1:0] in_instr;
   logic [priv_pkg::XLEN-1:0] in_rs1_value;
   logic                      ext_irq;
   logic                      sw_irq;
   logic                      timer_irq;
   logic                      in_ready;
   logic                      res_valid;
   logic [priv_pkg::XLEN-1:0] res_rd_data;
   logic                      res_rd_write;
   logic [priv_pkg::XLEN-1:0] res_next_pc;
   logic                      res_trap;
   priv_pkg::priv_mode_t      priv_mode;

   logic [31:0] vec_mem [0:MEM_WORDS-1];
   int          vec_count;
   int          vec_idx;
   int          cycle_count;
   int          cycle_limit;

   priv_unit #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_dut (
      .clk          (clk),
      .rstn         (rstn),
      .in_valid     (in_valid),
      .in_pc        (in_pc),
      .in_instr     (in_instr),
      .in_rs1_value (in_rs1_value),
      .ext_irq      (ext_irq),
      .sw_irq       (sw_irq),
      .timer_irq    (timer_irq),
      .in_ready     (in_ready),
      .res_valid    (res_valid),
      .res_rd_data  (res_rd_data),
      .res_rd_write (res_rd_write),
      .res_next_pc  (res_next_pc),
      .res_trap     (res_trap),
      .priv_mode    (priv_mode)
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   ////////////////////////////////////////
   // error handling
   ////////////////////////////////////////
   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [priv_pkg::XLEN-1:0] actual,
                             input logic [priv_pkg::XLEN-1:0] expected);
      if (actual !== expected) begin
         $display("FAIL vector %0d %s: got %h expected %h", vec_idx, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("FAIL vector %0d %s: got %h expected %h", vec_idx, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_mode(input string name, input priv_pkg::priv_mode_t actual,
                             input priv_pkg::priv_mode_t expected);
      if (actual !== expected) begin
         $display("FAIL vector %0d %s: got %h expected %h", vec_idx, name, actual, expected);
         abort_run();
      end
   endtask

   // run length is bounded by the vector count read from the file
   initial begin
      cycle_count = 0;
      while (cycle_count <= cycle_limit) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
   end

   ////////////////////////////////////////
   // one vector, driven then compared
   ////////////////////////////////////////
   task automatic apply_vector(input int base);
      while (!in_ready) begin
         @(negedge clk);
      end
      in_valid     = 1'b1;
      in_pc        = vec_mem[base];
      in_instr     = vec_mem[base + 1];
      in_rs1_value = vec_mem[base + 2];
      ext_irq      = vec_mem[base + 3][0];
      sw_irq       = vec_mem[base + 4][0];
      timer_irq    = vec_mem[base + 5][0];
      // accepted on the rising edge in between
      @(negedge clk);
      in_valid = 1'b0;
      while (!res_valid) begin
         @(negedge clk);
      end
      check_flag("res_rd_write", res_rd_write, vec_mem[base + 6][0]);
      check_word("res_rd_data", res_rd_data, vec_mem[base + 7]);
      check_word("res_next_pc", res_next_pc, vec_mem[base + 8]);
      check_flag("res_trap", res_trap, vec_mem[base + 9][0]);
      check_mode("priv_mode", priv_mode, priv_pkg::priv_mode_t'(vec_mem[base + 10][1:0]));
   endtask

   initial begin
      rstn         = 1'b1;
      in_valid     = 1'b0;
      in_pc        = '0;
      in_instr     = '0;
      in_rs1_value = '0;
      ext_irq      = 1'b0;
      sw_irq       = 1'b0;
      timer_irq    = 1'b0;
      vec_idx      = -1;

      $readmemh("priv_input.txt", vec_mem);
      vec_count   = vec_mem[0];
      cycle_limit = 4 * vec_count + 100;
      if (vec_count < 1 || vec_count > MAX_VECTORS) begin
         $display("priv_input.txt does not give a usable vector count");
         abort_run();
      end else begin
         repeat (16) @(negedge clk);
         rstn = 1'b0;
         @(negedge clk);

         // idle state right after reset
         check_flag("in_ready", in_ready, 1'b1);
         check_flag("res_valid", res_valid, 1'b0);
         check_flag("res_trap", res_trap, 1'b0);
         check_word("res_next_pc", res_next_pc, RESET_VECTOR);
         check_mode("priv_mode", priv_mode, priv_pkg::PRIV_M);

         for (vec_idx = 0; vec_idx < vec_count; vec_idx++) begin
            apply_vector(1 + vec_idx * WORDS_PER_VECTOR);
         end

         $display("%0d vectors checked in %0d cycles", vec_count, cycle_count);
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

//--- priv_input.txt
// pc instr rs1_value ext_irq sw_irq timer_irq, then expected:
// rd_write rd_data next_pc trap mode (3 = M, 0 = U); first entry is the vector count
29
00001000 340312f3 12345678 0 0 0 1 00000000 00001004 0 3
00001004 340322f3 0000ff00 0 0 0 1 12345678 00001008 0 3
00001008 340332f3 000000f0 0 0 0 1 1234ff78 0000100c 0 3
0000100c 340022f3 ffffffff 0 0 0 1 1234ff08 00001010 0 3
00001010 340472f3 00000000 0 0 0 1 1234ff08 00001014 0 3
// mstatus, mie and mtvec masks
00001014 300312f3 ffffffff 0 0 0 1 00000000 00001018 0 3
00001018 300022f3 00000000 0 0 0 1 00001888 0000101c 0 3
0000101c 304312f3 ffffffff 0 0 0 1 00000000 00001020 0 3
00001020 304012f3 00000000 0 0 0 1 00000888 00001024 0 3
00001024 305312f3 00002000 0 0 0 1 00000000 00001028 0 3
00001028 305312f3 00003002 0 0 0 1 00002000 0000102c 0 3
0000102c 305022f3 00000000 0 0 0 1 00002000 00001030 0 3
// mhartid write and unknown address
00001030 f14312f3 00000001 0 0 0 0 00000000 00002000 1 3
00002000 343022f3 00000000 0 0 0 1 f14312f3 00002004 0 3
00002004 7c0022f3 00000000 0 0 0 0 00000000 00002000 1 3
00002000 342022f3 00000000 0 0 0 1 00000002 00002004 0 3
// ecall, ebreak, mret into U mode
00002004 00000073 00000000 0 0 0 0 00000000 00002000 1 3
00002000 342022f3 00000000 0 0 0 1 0000000b 00002004 0 3
00002004 00100073 00000000 0 0 0 0 00000000 00002000 1 3
00002000 342022f3 00000000 0 0 0 1 00000003 00002004 0 3
00002004 300332f3 00001800 0 0 0 1 00001800 00002008 0 3
00002008 341312f3 00003000 0 0 0 1 00002004 0000200c 0 3
0000200c 30200073 00000000 0 0 0 0 00000000 00003000 0 0
00003000 00000073 00000000 0 0 0 0 00000000 00002000 1 3
00002000 342022f3 00000000 0 0 0 1 00000008 00002004 0 3
00002004 30200073 00000000 0 0 0 0 00000000 00003000 0 0
00003000 340022f3 00000000 0 0 0 0 00000000 00002000 1 3
00002000 342022f3 00000000 0 0 0 1 00000002 00002004 0 3
00002004 10500073 00000000 0 0 0 0 00000000 00002008 0 3
// interrupts with vectored mtvec
00002008 305312f3 00002001 0 0 0 1 00002000 0000200c 0 3
0000200c 304312f3 00000888 0 0 0 1 00000000 00002010 0 3
00002010 300462f3 00000000 0 0 0 1 00000000 00002014 0 3
00002014 340022f3 00000000 0 0 1 1 1234ff00 0000201c 1 3
0000201c 342022f3 00000000 0 0 1 1 80000007 00002020 0 3
00002020 300462f3 00000000 0 0 0 1 00001880 00002024 0 3
00002024 0ff0000f 00000000 1 1 0 0 00000000 0000202c 1 3
0000202c 342022f3 00000000 1 1 0 1 8000000b 00002030 0 3
// minstret, mip and misa
00002030 b02022f3 00000000 0 0 0 1 0000001f 00002034 0 3
00002034 344022f3 00000000 1 0 1 1 00000880 00002038 0 3
00002038 301022f3 00000000 0 0 0 1 40100100 0000203c 0 3
0000203c b02022f3 00000000 0 0 0 1 00000022 00002040 0 3

//--- sim.f
priv_pkg.sv
priv_decoder.sv
csr_file.sv
intr_ctrl.sv
trap_ctrl.sv
priv_unit.sv
tb_priv_unit.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_priv_unit -Mdir obj_dir -o tb_priv_unit
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_priv_unit)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
